// ==== source/revo_pkg.sv ====
package revo_pkg;

	// word and lane geometry
	localparam int BITS_PER_WORD = 8;
	localparam int N_LANES = 2;
	localparam int CLOCK_LANE = 0;
	localparam int REVO_LANE = 1;

	// scaled-down revolution, real ring is much longer
	localparam int WORDS_PER_REVO = 16;

	localparam int BIT_CNT_W = $clog2(BITS_PER_WORD);
	localparam int WORD_CNT_W = $clog2(WORDS_PER_REVO);

	// fixed clock lane pattern, one at the msb
	localparam logic [BITS_PER_WORD-1:0] CLOCK_WORD = 8'b1010_1010;

	// marker bit for phase 0, shifted right by the phase
	localparam logic [BITS_PER_WORD-1:0] MARKER_MSB = 8'b1000_0000;

	// reset release points, counted from rst_n going high
	localparam int CORE_RESET_CYCLES = 16;
	localparam int GEN_RESET_CYCLES = 64;

	// sequencer counter
	localparam int SEQ_CNT_W = 8;
	localparam int HEARTBEAT_BIT = 5;

	// one word per lane
	// first member sits in the upper bits, so clock_word ends up in lane 0's slot
	typedef struct packed {
		logic [BITS_PER_WORD-1:0] revo_word;
		logic [BITS_PER_WORD-1:0] clock_word;
	} lane_words_t;

	// per-lane load indication, bit i is lane i
	typedef struct packed {
		logic [N_LANES-1:0] loaded;
	} lane_status_t;

	typedef enum logic [1:0] {
		IDLE,
		ALIGN,
		RUN
	} gen_state_t;

endpackage

// ==== source/reset_sequencer.sv ====
`timescale 1ns/1ps

module reset_sequencer (
	input  logic clock50,
	input  logic rst_n,
	output logic core_rst_n,
	output logic gen_rst_n,
	output logic heartbeat
);

	logic [revo_pkg::SEQ_CNT_W-1:0] count;

	// free-running, so the releases below must be sticky
	always_ff @(posedge clock50) begin
		if (!rst_n) begin
			count <= '0;
			core_rst_n <= 1'b0;
			gen_rst_n <= 1'b0;
		end else begin
			count <= count + 1'b1;
			// lanes and output stage come out first
			if (count == revo_pkg::SEQ_CNT_W'(revo_pkg::CORE_RESET_CYCLES - 1)) begin
				core_rst_n <= 1'b1;
			end
			// generator only after the lanes are ready
			if (count == revo_pkg::SEQ_CNT_W'(revo_pkg::GEN_RESET_CYCLES - 1)) begin
				gen_rst_n <= 1'b1;
			end
		end
	end

	// slow blink for the board
	assign heartbeat = count[revo_pkg::HEARTBEAT_BIT];

endmodule

// ==== source/revo_word_gen.sv ====
`timescale 1ns/1ps

module revo_word_gen (
	input  logic clock50,
	input  logic gen_rst_n,
	input  logic run,
	input  logic [revo_pkg::BIT_CNT_W-1:0] marker_phase,
	output revo_pkg::lane_words_t lane_words,
	output logic word_load,
	output logic marker_word
);

	revo_pkg::gen_state_t state;
	logic [revo_pkg::BIT_CNT_W-1:0] bit_cnt;
	logic [revo_pkg::WORD_CNT_W-1:0] word_cnt;
	logic load_next;
	logic first_word;

	// next cycle carries a load strobe
	// either leaving ALIGN or at the last bit of a running word
	assign load_next = (state == revo_pkg::ALIGN) ||
		((state == revo_pkg::RUN) &&
		(bit_cnt == revo_pkg::BIT_CNT_W'(revo_pkg::BITS_PER_WORD - 1)));

	// word_cnt is the index of the word about to be loaded
	assign first_word = (word_cnt == '0);

	always_ff @(posedge clock50) begin
		if (!gen_rst_n || !run) begin
			// dropping run also restarts the revolution at word 0
			state <= revo_pkg::IDLE;
			bit_cnt <= '0;
			word_cnt <= '0;
			word_load <= 1'b0;
			marker_word <= 1'b0;
		end else begin
			case (state)
				revo_pkg::IDLE: begin
					state <= revo_pkg::ALIGN;
				end
				revo_pkg::ALIGN: begin
					state <= revo_pkg::RUN;
				end
				default: begin
					state <= revo_pkg::RUN;
				end
			endcase

			// bit position only advances while running
			if (state == revo_pkg::RUN) begin
				bit_cnt <= bit_cnt + 1'b1;
			end else begin
				bit_cnt <= '0;
			end

			word_load <= load_next;
			if (load_next) begin
				marker_word <= first_word;
				if (word_cnt == revo_pkg::WORD_CNT_W'(revo_pkg::WORDS_PER_REVO - 1)) begin
					word_cnt <= '0;
				end else begin
					word_cnt <= word_cnt + 1'b1;
				end
			end
		end
	end

	// lane payload, built alongside the strobe
	// phase is sampled here, at the word 0 load
	always_ff @(posedge clock50) begin
		if (load_next) begin
			lane_words.clock_word <= revo_pkg::CLOCK_WORD;
			if (first_word) begin
				lane_words.revo_word <= revo_pkg::MARKER_MSB >> marker_phase;
			end else begin
				lane_words.revo_word <= '0;
			end
		end
	end

endmodule

// ==== source/lane_serializer.sv ====
`timescale 1ns/1ps

module lane_serializer (
	input  logic clock50,
	input  logic core_rst_n,
	input  logic word_load,
	input  logic [revo_pkg::BITS_PER_WORD-1:0] word,
	output logic bit_out,
	output logic loaded
);

	logic [revo_pkg::BITS_PER_WORD-1:0] shreg;

	// msb first, zeros shifted in behind the word
	always_ff @(posedge clock50) begin
		if (!core_rst_n) begin
			shreg <= '0;
		end else if (word_load) begin
			shreg <= word;
		end else begin
			shreg <= {shreg[revo_pkg::BITS_PER_WORD-2:0], 1'b0};
		end
	end

	// stands in for the serializer lock
	// goes high at the first word and stays there
	always_ff @(posedge clock50) begin
		if (!core_rst_n) begin
			loaded <= 1'b0;
		end else if (word_load) begin
			loaded <= 1'b1;
		end
	end

	// bit 7 shows up the cycle after the load
	assign bit_out = shreg[revo_pkg::BITS_PER_WORD-1];

endmodule

// ==== source/output_stage.sv ====
`timescale 1ns/1ps

module output_stage (
	input  logic clock50,
	input  logic core_rst_n,
	input  logic [revo_pkg::N_LANES-1:0] lane_bits,
	input  revo_pkg::lane_status_t lane_status,
	input  logic word_load,
	input  logic marker_word,
	input  logic heartbeat,
	input  logic gen_rst_n,
	output logic clk_out,
	output logic trg_out,
	output logic word_sync,
	output logic revo,
	output logic [7:0] led
);

	logic load_d;
	logic [revo_pkg::BIT_CNT_W-1:0] revo_cnt;
	logic heartbeat_q;
	logic gen_rst_q;
	logic core_rst_q;
	logic [revo_pkg::N_LANES-1:0] loaded_q;

	always_ff @(posedge clock50) begin
		if (!core_rst_n) begin
			clk_out <= 1'b0;
			trg_out <= 1'b0;
			load_d <= 1'b0;
			word_sync <= 1'b0;
			revo <= 1'b0;
			revo_cnt <= '0;
		end else begin
			clk_out <= lane_bits[revo_pkg::CLOCK_LANE];
			trg_out <= lane_bits[revo_pkg::REVO_LANE];
			// two stages line up with bit 7 on the outputs
			load_d <= word_load;
			word_sync <= load_d;
			// marker_word is still valid one cycle after the load
			if (load_d) begin
				revo <= marker_word;
				revo_cnt <= revo_pkg::BIT_CNT_W'(revo_pkg::BITS_PER_WORD - 1);
			end else if (revo_cnt != '0) begin
				revo_cnt <= revo_cnt - 1'b1;
			end else begin
				revo <= 1'b0;
			end
		end
	end

	// status snapshot for the leds
	always_ff @(posedge clock50) begin
		heartbeat_q <= heartbeat;
		gen_rst_q <= ~gen_rst_n;
		core_rst_q <= ~core_rst_n;
		loaded_q <= lane_status.loaded;
	end

	assign led = {
		loaded_q[revo_pkg::REVO_LANE],
		loaded_q[revo_pkg::CLOCK_LANE],
		1'b0,
		revo,
		1'b0,
		core_rst_q,
		gen_rst_q,
		heartbeat_q
	};

endmodule

// ==== source/revo_timing_top.sv ====
`timescale 1ns/1ps

module revo_timing_top (
	input  logic clock50,
	input  logic rst_n,
	input  logic run,
	input  logic [revo_pkg::BIT_CNT_W-1:0] marker_phase,
	output logic clk_out,
	output logic trg_out,
	output logic word_sync,
	output logic revo,
	output logic [7:0] led
);

	localparam int LANE_BUS_W = revo_pkg::N_LANES * revo_pkg::BITS_PER_WORD;

	logic core_rst_n;
	logic gen_rst_n;
	logic heartbeat;
	revo_pkg::lane_words_t lane_words;
	logic word_load;
	logic marker_word;
	logic [LANE_BUS_W-1:0] lane_words_flat;
	logic [revo_pkg::N_LANES-1:0] lane_bits;
	logic [revo_pkg::N_LANES-1:0] lane_loaded;
	revo_pkg::lane_status_t lane_status;

	reset_sequencer u_rst_seq (
		.clock50    (clock50),
		.rst_n      (rst_n),
		.core_rst_n (core_rst_n),
		.gen_rst_n  (gen_rst_n),
		.heartbeat  (heartbeat)
	);

	revo_word_gen u_word_gen (
		.clock50      (clock50),
		.gen_rst_n    (gen_rst_n),
		.run          (run),
		.marker_phase (marker_phase),
		.lane_words   (lane_words),
		.word_load    (word_load),
		.marker_word  (marker_word)
	);

	// lane i takes slice i of the word struct
	assign lane_words_flat = lane_words;

	for (genvar i = 0; i < revo_pkg::N_LANES; i++) begin : g_lane
		lane_serializer u_lane (
			.clock50    (clock50),
			.core_rst_n (core_rst_n),
			.word_load  (word_load),
			.word       (lane_words_flat[i*revo_pkg::BITS_PER_WORD +: revo_pkg::BITS_PER_WORD]),
			.bit_out    (lane_bits[i]),
			.loaded     (lane_loaded[i])
		);
	end

	assign lane_status.loaded = lane_loaded;

	output_stage u_out (
		.clock50     (clock50),
		.core_rst_n  (core_rst_n),
		.lane_bits   (lane_bits),
		.lane_status (lane_status),
		.word_load   (word_load),
		.marker_word (marker_word),
		.heartbeat   (heartbeat),
		.gen_rst_n   (gen_rst_n),
		.clk_out     (clk_out),
		.trg_out     (trg_out),
		.word_sync   (word_sync),
		.revo        (revo),
		.led         (led)
	);

endmodule

// ==== dv/revo_timing_sva.sv ====
`timescale 1ns/1ps

module revo_timing_sva (
	input logic clock50,
	input logic blk_rst_n,
	input logic strobe,
	input logic running,
	input logic trg,
	input logic revo_lvl,
	input logic [3:0] outs
);

	localparam int PERIOD = revo_pkg::BITS_PER_WORD;
	localparam int GAP = revo_pkg::BITS_PER_WORD - 1;

	// no second strobe inside one word period
	word_spacing_a: assert property (@(posedge clock50) disable iff (!blk_rst_n)
		strobe |=> !strobe [*GAP])
		else $error("word strobe repeated inside a word period");

	// next strobe exactly one word later unless the generator stopped
	word_period_a: assert property (@(posedge clock50) disable iff (!blk_rst_n)
		strobe && running |-> ##PERIOD (strobe || !running))
		else $error("word strobe missing one word period after the last one");

	// trigger bit only inside a marker word
	marker_a: assert property (@(posedge clock50) trg |-> revo_lvl)
		else $error("trigger seen outside the marker word");

	// block held in reset drives its outputs low
	reset_low_a: assert property (@(posedge clock50) !blk_rst_n |=> (outs == '0))
		else $error("outputs not low while the block is held in reset");

endmodule

// strobe only while the generator is running
bind revo_word_gen revo_timing_sva sva_gen (
	.clock50   (clock50),
	.blk_rst_n (gen_rst_n),
	.strobe    (word_load),
	.running   (state == revo_pkg::RUN),
	.trg       (word_load),
	.revo_lvl  (state == revo_pkg::RUN),
	.outs      ({word_load, marker_word, 2'b00})
);

// a new word on the clock lane starts with a one, so word_sync must be there
bind output_stage revo_timing_sva sva_out (
	.clock50   (clock50),
	.blk_rst_n (core_rst_n),
	.strobe    (word_sync),
	.running   (clk_out),
	.trg       (trg_out),
	.revo_lvl  (revo),
	.outs      ({clk_out, trg_out, word_sync, revo})
);

// ==== dv/revo_timing_tb.sv ====
`timescale 1ns/1ps

module revo_timing_tb;

	localparam int BPW = revo_pkg::BITS_PER_WORD;
	localparam int WPR = revo_pkg::WORDS_PER_REVO;
	localparam logic [31:0] SEED = 32'hbec3_0ab3;

	// test lengths in clock cycles
	localparam int RESET_TEST_CYCLES = revo_pkg::GEN_RESET_CYCLES + 12;
	localparam int CLOCK_WORDS = 20;
	localparam int MARKER_REVS = 5;
	localparam int RESTARTS = 2;
	localparam int STOP_CYCLES = 30;
	localparam int STATUS_CYCLES = 160;
	localparam int SYNC_TIMEOUT = 4 * BPW;
	localparam int WATCHDOG_CYCLES = RESET_TEST_CYCLES + (CLOCK_WORDS + 1) * BPW +
		(MARKER_REVS + 2) * WPR * BPW + RESTARTS * (STOP_CYCLES + (WPR + 2) * BPW) +
		STATUS_CYCLES + 200;

	logic clock50;
	logic rst_n;
	logic run;
	logic [revo_pkg::BIT_CNT_W-1:0] marker_phase;
	logic clk_out;
	logic trg_out;
	logic word_sync;
	logic revo;
	logic [7:0] led;

	string test_name = "startup";
	logic check_en = 1'b0;
	logic revo_at_sync = 1'b0;
	int sync_count = 0;

	// reference model state, updated by the comparing process
	int bit_pos = 0;
	int word_idx = 0;
	int words_seen = 0;
	logic in_word = 1'b0;
	logic is_marker = 1'b0;
	logic restart = 1'b1;
	logic [revo_pkg::BIT_CNT_W-1:0] marker_q = '0;

	revo_timing_top dut0 (
		.clock50      (clock50),
		.rst_n        (rst_n),
		.run          (run),
		.marker_phase (marker_phase),
		.clk_out      (clk_out),
		.trg_out      (trg_out),
		.word_sync    (word_sync),
		.revo         (revo),
		.led          (led)
	);

	initial begin
		clock50 = 1'b0;
		forever #5 clock50 = ~clock50;
	end

	task automatic stop_on_error(input string line);
		$display("%s", line);
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		assert (act === exp) else begin
			stop_on_error($sformatf("MISMATCH %s %s: expected %b, actual %b",
				test_name, what, exp, act));
		end
	endtask

	task automatic check_true(input logic cond, input string msg);
		assert (cond) else begin
			stop_on_error($sformatf("%s: %s", test_name, msg));
		end
	endtask

	// clk_out and trg_out for one output cycle of a word
	function automatic logic [1:0] expected_bits(input int pos, input logic marker,
		input logic [revo_pkg::BIT_CNT_W-1:0] phase);
		logic clk_bit;
		logic trg_bit;
		// clock lane alternates, starting with a one
		clk_bit = ((pos % 2) == 0);
		// one-hot marker lands phase cycles after the sync
		trg_bit = marker && (pos == int'(phase));
		return {clk_bit, trg_bit};
	endfunction

	function automatic logic [revo_pkg::BIT_CNT_W-1:0] random_phase();
		return revo_pkg::BIT_CNT_W'($urandom % BPW);
	endfunction

	// comparing process, outputs are stable at the falling edge
	always @(negedge clock50) begin
		logic [1:0] exp_bits;
		if (check_en) begin
			if (word_sync) begin
				check_true(!in_word || bit_pos == BPW - 1, "word_sync arrived inside a word");
				in_word = 1'b1;
				bit_pos = 0;
				word_idx = restart ? 0 : (word_idx + 1) % WPR;
				restart = 1'b0;
				is_marker = (word_idx == 0);
				if (is_marker) begin
					marker_q = marker_phase;
				end
				words_seen++;
			end else if (in_word) begin
				if (bit_pos == BPW - 1) begin
					check_true(!run, "word_sync missing after a full word");
					in_word = 1'b0;
				end else begin
					bit_pos++;
				end
			end
			if (!run) begin
				restart = 1'b1;
			end
			exp_bits = in_word ? expected_bits(bit_pos, is_marker, marker_q) : 2'b00;
			check_bit("clk_out", exp_bits[1], clk_out);
			check_bit("trg_out", exp_bits[0], trg_out);
			check_bit("revo", in_word && is_marker, revo);
			check_bit("led[4]", in_word && is_marker, led[4]);
			check_bit("led[3]", 1'b0, led[3]);
			check_bit("led[5]", 1'b0, led[5]);
			check_bit("led[6]", words_seen > 0, led[6]);
			check_bit("led[7]", words_seen > 0, led[7]);
		end
	end

	// returns just after the rising edge that follows the sync cycle
	task automatic wait_word_sync();
		int waited;
		waited = 0;
		@(negedge clock50);
		while (word_sync !== 1'b1) begin
			waited++;
			check_true(waited < SYNC_TIMEOUT,
				$sformatf("no word_sync within %0d cycles", SYNC_TIMEOUT));
			@(negedge clock50);
		end
		revo_at_sync = revo;
		sync_count++;
		@(posedge clock50);
		#1;
	endtask

	task automatic check_reset_release();
		int core_fall;
		int gen_fall;
		core_fall = -1;
		gen_fall = -1;
		test_name = "reset";
		// loop index counts rising edges since rst_n went high
		for (int edges = 0; edges <= revo_pkg::GEN_RESET_CYCLES + 4; edges++) begin
			@(negedge clock50);
			if (core_fall >= 0) begin
				check_bit("led[2] after release", 1'b0, led[2]);
			end else if (led[2] === 1'b0) begin
				core_fall = edges;
			end else begin
				check_bit("led[2] in reset", 1'b1, led[2]);
			end
			if (gen_fall >= 0) begin
				check_bit("led[1] after release", 1'b0, led[1]);
			end else if (led[1] === 1'b0) begin
				gen_fall = edges;
			end else begin
				check_bit("led[1] in reset", 1'b1, led[1]);
			end
		end
		check_true(core_fall >= revo_pkg::CORE_RESET_CYCLES &&
			core_fall <= revo_pkg::CORE_RESET_CYCLES + 2,
			$sformatf("core reset released after %0d cycles", core_fall));
		check_true(gen_fall >= revo_pkg::GEN_RESET_CYCLES &&
			gen_fall <= revo_pkg::GEN_RESET_CYCLES + 2,
			$sformatf("generator reset released after %0d cycles", gen_fall));
		check_true(core_fall < gen_fall, "generator reset released before the core reset");
	endtask

	task automatic check_clock_lane();
		test_name = "clock lane";
		@(posedge clock50);
		#1;
		run = 1'b1;
		sync_count = 0;
		wait_word_sync();
		check_bit("first word is marker", 1'b1, revo_at_sync);
		repeat (CLOCK_WORDS - 1) wait_word_sync();
	endtask

	// phase changes land mid-revolution, well away from the word 0 load
	task automatic check_markers();
		test_name = "marker";
		for (int r = 0; r < MARKER_REVS; r++) begin
			do begin
				wait_word_sync();
			end while ((sync_count - 1) % WPR != WPR / 2);
			marker_phase = random_phase();
		end
		repeat (WPR) wait_word_sync();
	endtask

	task automatic check_restart();
		test_name = "run restart";
		for (int r = 0; r < RESTARTS; r++) begin
			wait_word_sync();
			run = 1'b0;
			repeat (STOP_CYCLES) begin
				@(negedge clock50);
				check_true(word_sync !== 1'b1, "word_sync still pulsing with run low");
			end
			@(posedge clock50);
			#1;
			marker_phase = random_phase();
			run = 1'b1;
			sync_count = 0;
			wait_word_sync();
			check_bit("first word after restart is marker", 1'b1, revo_at_sync);
			repeat (WPR) wait_word_sync();
		end
	endtask

	task automatic check_status();
		int toggles;
		logic last_hb;
		test_name = "status";
		toggles = 0;
		@(negedge clock50);
		last_hb = led[0];
		repeat (STATUS_CYCLES) begin
			@(negedge clock50);
			if (led[0] !== last_hb) begin
				toggles++;
			end
			last_hb = led[0];
		end
		// heartbeat flips every 2**HEARTBEAT_BIT cycles
		check_true(toggles >= STATUS_CYCLES / (2 ** revo_pkg::HEARTBEAT_BIT) - 1,
			$sformatf("heartbeat led toggled only %0d times", toggles));
		check_bit("led[1] while running", 1'b0, led[1]);
		check_bit("led[2] while running", 1'b0, led[2]);
	endtask

	initial begin
		int unsigned seed_val;
		rst_n = 1'b0;
		run = 1'b0;
		marker_phase = '0;
		seed_val = $urandom(SEED);
		repeat (4) @(posedge clock50);
		#1;
		rst_n = 1'b1;
		check_en = 1'b1;
		check_reset_release();
		check_clock_lane();
		check_markers();
		check_restart();
		check_status();
		$display("PASS: all tests");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock50);
		stop_on_error($sformatf("timeout, run still going after %0d cycles",
			WATCHDOG_CYCLES));
	end

endmodule

// ==== tb.f ====
source/revo_pkg.sv
source/reset_sequencer.sv
source/revo_word_gen.sv
source/lane_serializer.sv
source/output_stage.sv
source/revo_timing_top.sv
dv/revo_timing_sva.sv
dv/revo_timing_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -Wno-fatal -j 0
TOP       := revo_timing_tb
FILELIST  := tb.f
BUILD_DIR := obj_dir

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
